/* logic/addr_decoder.sv */
`timescale 1ns/1ns

module addr_decoder (
  input  logic                       clk_i,
  input  logic                       rstn_i,
  input  logic                       tile_enable_i,
  input  logic                       req_valid_i,
  input  tile_types_pkg::tile_addr_u req_addr_i,
  input  logic                       req_we_i,
  input  tile_types_pkg::word_t      req_wdata_i,
  input  tile_types_pkg::be_t        req_be_i,
  mem_req_if.producer                req_o
);

  logic                       en_q;       // Registered tile enable, gates requests
  logic                       valid_q;    // Accepted request strobe
  tile_types_pkg::target_e    target_d;   // Region of the incoming address
  tile_types_pkg::target_e    target_q;
  tile_types_pkg::tile_addr_u addr_q;
  logic                       we_q;
  tile_types_pkg::word_t      wdata_q;
  tile_types_pkg::be_t        be_q;

  // Region compare on the flat view
  always_comb begin
    if (req_addr_i.raw >= tile_cfg_pkg::L1_ADDR_START &&
        req_addr_i.raw <= tile_cfg_pkg::L1_ADDR_END) begin
      target_d = tile_types_pkg::TGT_L1;
    end else if (req_addr_i.raw >= tile_cfg_pkg::L2_ADDR_START &&
                 req_addr_i.raw <= tile_cfg_pkg::L2_ADDR_END) begin
      target_d = tile_types_pkg::TGT_L2;
    end else begin
      target_d = tile_types_pkg::TGT_ERR;  // Outside both maps
    end
  end

  always_ff @(posedge clk_i, negedge rstn_i) begin
    if (!rstn_i) begin
      en_q    <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      en_q    <= tile_enable_i;            // Takes effect one edge later
      valid_q <= req_valid_i & en_q;       // Dropped while disabled, no response
    end
  end

  // Payload only, qualified by valid_q
  always_ff @(posedge clk_i) begin
    if (req_valid_i && en_q) begin
      target_q <= target_d;
      addr_q   <= req_addr_i;
      we_q     <= req_we_i;
      wdata_q  <= req_wdata_i;
      be_q     <= req_be_i;
    end
  end

  assign req_o.valid  = valid_q;
  assign req_o.target = target_q;
  assign req_o.addr   = addr_q;
  assign req_o.we     = we_q;
  assign req_o.wdata  = wdata_q;
  assign req_o.be     = be_q;

endmodule

/* logic/l1_spm.sv */
`timescale 1ns/1ns

module l1_spm (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  mem_req_if.consumer           req_i,
  output logic                  rsp_valid_o,
  output tile_types_pkg::word_t rdata_o,
  output logic                  err_o
);

  logic                              l1_req;                                // Strobe aimed at L1
  logic                              rsp_valid_q;
  logic [tile_cfg_pkg::BANK_W-1:0]   bank_sel_q;                            // Bank of last access
  tile_types_pkg::word_t             bank_rd_q [tile_cfg_pkg::N_BANKS];     // Per-bank read regs

  assign l1_req = req_i.valid && (req_i.target == tile_types_pkg::TGT_L1);

  for (genvar g = 0; g < tile_cfg_pkg::N_BANKS; g++) begin : gen_bank
    logic                  bank_req;   // This bank is addressed
    tile_types_pkg::word_t mem_q [tile_cfg_pkg::N_WORDS_BANK] = '{default: '0};

    assign bank_req = l1_req && (req_i.addr.l1.bank == g[tile_cfg_pkg::BANK_W-1:0]);

    always_ff @(posedge clk_i) begin
      if (bank_req) begin
        if (req_i.we) begin
          for (int b = 0; b < tile_cfg_pkg::BE_W; b++) begin
            if (req_i.be[b]) begin
              mem_q[req_i.addr.l1.row][b*8 +: 8] <= req_i.wdata[b*8 +: 8];  // Byte lane write
            end
          end
          bank_rd_q[g] <= '0;                                  // Store returns zero data
        end else begin
          bank_rd_q[g] <= mem_q[req_i.addr.l1.row];            // Registered read
        end
      end
    end
  end

  // Bank select kept alongside the read data
  always_ff @(posedge clk_i) begin
    if (l1_req) begin
      bank_sel_q <= req_i.addr.l1.bank;
    end
  end

  always_ff @(posedge clk_i, negedge rstn_i) begin
    if (!rstn_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= l1_req;           // One cycle access latency
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rdata_o     = bank_rd_q[bank_sel_q];  // Output mux over banks
  assign err_o       = 1'b0;                   // Every L1 address maps to a word

endmodule

/* logic/mem_req_if.sv */
`timescale 1ns/1ns

interface mem_req_if;

  logic                        valid;   // Single-cycle strobe, no back-pressure
  tile_types_pkg::target_e     target;  // Decoded region
  tile_types_pkg::tile_addr_u  addr;    // Byte address, two views
  logic                        we;      // 1 = store, 0 = load
  tile_types_pkg::word_t       wdata;   // Store data
  tile_types_pkg::be_t         be;      // Store byte enables

  // Decoder side
  modport producer (
    output valid, target, addr, we, wdata, be
  );

  // Scratchpad and merger side, each acts on its own target only
  modport consumer (
    input  valid, target, addr, we, wdata, be
  );

endinterface

/* logic/rsp_merger.sv */
`timescale 1ns/1ns

module rsp_merger (
  input  logic                              clk_i,
  input  logic                              rstn_i,
  mem_req_if.consumer                       req_i,
  input  logic                              l1_rsp_valid_i,
  input  tile_types_pkg::word_t             l1_rdata_i,
  input  logic                              l1_err_i,
  output logic                              l2_req_valid_o,
  output logic [tile_cfg_pkg::ADDR_W-1:0]   l2_req_addr_o,
  output logic                              l2_req_we_o,
  output tile_types_pkg::word_t             l2_req_wdata_o,
  output tile_types_pkg::be_t               l2_req_be_o,
  input  logic                              l2_rsp_valid_i,
  input  tile_types_pkg::word_t             l2_rdata_i,
  output logic                              rsp_valid_o,
  output tile_types_pkg::word_t             rsp_rdata_o,
  output logic                              rsp_err_o,
  output logic                              busy_o
);

  logic                  l2_req;       // Strobe aimed at L2
  logic                  err_req;      // Strobe to an unmapped address
  logic                  l2_ret;       // L2 answer for the outstanding request
  logic                  pending_q;    // One L2 request in flight
  logic                  err_q;        // Error strobe delayed to L1 timing
  logic                  rsp_valid_q;
  tile_types_pkg::word_t rsp_rdata_q;
  logic                  rsp_err_q;

  assign l2_req  = req_i.valid && (req_i.target == tile_types_pkg::TGT_L2);
  assign err_req = req_i.valid && (req_i.target == tile_types_pkg::TGT_ERR);
  assign l2_ret  = l2_rsp_valid_i && pending_q;  // Stray returns are ignored

  // L2 port, forwarded in the cycle the strobe arrives
  assign l2_req_valid_o = l2_req;
  assign l2_req_addr_o  = req_i.addr.raw;       // Flat address goes out
  assign l2_req_we_o    = req_i.we;
  assign l2_req_wdata_o = req_i.wdata;
  assign l2_req_be_o    = req_i.be;

  always_ff @(posedge clk_i, negedge rstn_i) begin
    if (!rstn_i) begin
      pending_q   <= 1'b0;
      err_q       <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (l2_req) begin
        pending_q <= 1'b1;
      end else if (l2_ret) begin
        pending_q <= 1'b0;       // Clears with the returned response
      end
      err_q       <= err_req;
      rsp_valid_q <= l1_rsp_valid_i | err_q | l2_ret;
    end
  end

  // Sources never overlap while the requester obeys busy_o
  always_ff @(posedge clk_i) begin
    if (l1_rsp_valid_i) begin
      rsp_rdata_q <= l1_rdata_i;
      rsp_err_q   <= l1_err_i;
    end else if (err_q) begin
      rsp_rdata_q <= '0;          // Error carries no data
      rsp_err_q   <= 1'b1;
    end else if (l2_ret) begin
      rsp_rdata_q <= l2_rdata_i;
      rsp_err_q   <= 1'b0;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_rdata_o = rsp_rdata_q;
  assign rsp_err_o   = rsp_err_q;
  assign busy_o      = l2_req | pending_q;  // Up with the L2 strobe, down with the response

endmodule

/* logic/tile_cfg_pkg.sv */
package tile_cfg_pkg;

  // Bus widths
  localparam int unsigned DATA_W = 32;            // Data word width
  localparam int unsigned ADDR_W = 32;            // Byte address width
  localparam int unsigned BE_W   = DATA_W / 8;    // One enable bit per byte lane

  // Scratchpad geometry
  localparam int unsigned N_BANKS      = 4;       // Word-interleaved banks
  localparam int unsigned N_WORDS_BANK = 64;      // Depth of each bank

  // Address field widths, LSB first: byte offset, bank, row, region tag
  localparam int unsigned BYTE_W = $clog2(BE_W);          // 2 bits of byte offset
  localparam int unsigned BANK_W = $clog2(N_BANKS);       // 2 bits of bank select
  localparam int unsigned ROW_W  = $clog2(N_WORDS_BANK);  // 6 bits of row index
  localparam int unsigned TAG_W  = ADDR_W - ROW_W - BANK_W - BYTE_W;  // 22 bits left above

  // Local L1 region, 1 KiB = N_BANKS * N_WORDS_BANK words
  localparam logic [ADDR_W-1:0] L1_ADDR_START = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] L1_ADDR_END   = 32'h1000_03FF;

  // External L2 region, reached through the L2 port
  localparam logic [ADDR_W-1:0] L2_ADDR_START = 32'h2000_0000;
  localparam logic [ADDR_W-1:0] L2_ADDR_END   = 32'h2FFF_FFFF;

endpackage

/* logic/tile_mem_path.sv */
`timescale 1ns/1ns

module tile_mem_path (
  input  logic                              clk_i,
  input  logic                              rstn_i,
  input  logic                              tile_enable_i,

  // Requester side
  input  logic                              req_valid_i,
  input  tile_types_pkg::tile_addr_u        req_addr_i,
  input  logic                              req_we_i,
  input  tile_types_pkg::word_t             req_wdata_i,
  input  tile_types_pkg::be_t               req_be_i,
  output logic                              rsp_valid_o,
  output tile_types_pkg::word_t             rsp_rdata_o,
  output logic                              rsp_err_o,
  output logic                              busy_o,

  // L2 side
  output logic                              l2_req_valid_o,
  output logic [tile_cfg_pkg::ADDR_W-1:0]   l2_req_addr_o,
  output logic                              l2_req_we_o,
  output tile_types_pkg::word_t             l2_req_wdata_o,
  output tile_types_pkg::be_t               l2_req_be_o,
  input  logic                              l2_rsp_valid_i,
  input  tile_types_pkg::word_t             l2_rsp_rdata_i
);

  mem_req_if req_if ();                 // Decoded request, one producer and two readers

  logic                  l1_rsp_valid;  // Scratchpad response
  tile_types_pkg::word_t l1_rdata;
  logic                  l1_err;

  addr_decoder addr_decoder_inst (
    .clk_i         ( clk_i         ),
    .rstn_i        ( rstn_i        ),
    .tile_enable_i ( tile_enable_i ),
    .req_valid_i   ( req_valid_i   ),
    .req_addr_i    ( req_addr_i    ),
    .req_we_i      ( req_we_i      ),
    .req_wdata_i   ( req_wdata_i   ),
    .req_be_i      ( req_be_i      ),
    .req_o         ( req_if        )
  );

  l1_spm l1_spm_inst (
    .clk_i       ( clk_i        ),
    .rstn_i      ( rstn_i       ),
    .req_i       ( req_if       ),
    .rsp_valid_o ( l1_rsp_valid ),
    .rdata_o     ( l1_rdata     ),
    .err_o       ( l1_err       )
  );

  rsp_merger rsp_merger_inst (
    .clk_i          ( clk_i          ),
    .rstn_i         ( rstn_i         ),
    .req_i          ( req_if         ),
    .l1_rsp_valid_i ( l1_rsp_valid   ),
    .l1_rdata_i     ( l1_rdata       ),
    .l1_err_i       ( l1_err         ),
    .l2_req_valid_o ( l2_req_valid_o ),
    .l2_req_addr_o  ( l2_req_addr_o  ),
    .l2_req_we_o    ( l2_req_we_o    ),
    .l2_req_wdata_o ( l2_req_wdata_o ),
    .l2_req_be_o    ( l2_req_be_o    ),
    .l2_rsp_valid_i ( l2_rsp_valid_i ),
    .l2_rdata_i     ( l2_rsp_rdata_i ),
    .rsp_valid_o    ( rsp_valid_o    ),
    .rsp_rdata_o    ( rsp_rdata_o    ),
    .rsp_err_o      ( rsp_err_o      ),
    .busy_o         ( busy_o         )
  );

endmodule

/* logic/tile_types_pkg.sv */
package tile_types_pkg;

  // One data word as it travels on every port
  typedef logic [tile_cfg_pkg::DATA_W-1:0] word_t;

  // Byte lane enables of a store
  typedef logic [tile_cfg_pkg::BE_W-1:0] be_t;

  // Destination of a decoded request
  typedef enum logic [1:0] {
    TGT_L1  = 2'd0,   // Local scratchpad
    TGT_L2  = 2'd1,   // External L2 port
    TGT_ERR = 2'd2    // Unmapped, answered with an error
  } target_e;

  // Same address word seen flat or split into scratchpad fields
  typedef union packed {
    logic [tile_cfg_pkg::ADDR_W-1:0] raw;   // Region compare and L2 address
    struct packed {
      logic [tile_cfg_pkg::TAG_W-1:0]  tag;     // Region tag, checked by the decoder
      logic [tile_cfg_pkg::ROW_W-1:0]  row;     // Word row inside a bank
      logic [tile_cfg_pkg::BANK_W-1:0] bank;    // Low word bits pick the bank
      logic [tile_cfg_pkg::BYTE_W-1:0] offset;  // Byte in word, unused for word access
    } l1;
  } tile_addr_u;

endpackage

/* run.sh */
#!/bin/sh
# Build and run the tile memory path testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_tile_mem_path -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_tile_mem_path > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" "$LOG"; then
  exit 1
fi
exit 0

/* tb.f */
logic/tile_cfg_pkg.sv
logic/tile_types_pkg.sv
logic/mem_req_if.sv
logic/addr_decoder.sv
logic/l1_spm.sv
logic/rsp_merger.sv
logic/tile_mem_path.sv
verification/tile_mem_path_props.sv
verification/tb_tile_mem_path.sv

/* verification/tb_tile_mem_path.sv */
`timescale 1ns/1ns

module tb_tile_mem_path;

  localparam int MAX_CYCLES = 2000;  // Far above the roughly 150 cycles of all tests

  logic clk_i, rstn_i, tile_enable_i, req_valid_i, req_we_i;
  tile_types_pkg::tile_addr_u      req_addr_i;
  tile_types_pkg::word_t           req_wdata_i, rsp_rdata_o, l2_req_wdata_o, l2_rsp_rdata_i;
  tile_types_pkg::be_t             req_be_i, l2_req_be_o;
  logic rsp_valid_o, rsp_err_o, busy_o, l2_req_valid_o, l2_req_we_o, l2_rsp_valid_i;
  logic [tile_cfg_pkg::ADDR_W-1:0] l2_req_addr_o;

  int err_cnt    = 0;  // Wrong values
  int miss_cnt   = 0;  // Missing, early or stray responses
  int cycle_cnt  = 0;
  int l2_req_cnt = 0;  // Requests seen by the L2 model
  tile_types_pkg::word_t l1_shadow [256] = '{default: '0};  // Expected L1 words by index
  tile_types_pkg::word_t l2_mem [logic [31:0]];             // L2 model storage

  tile_mem_path tile_mem_path_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("test failed");
      $finish;
    end
  end

  task automatic tick();  // Just past the next rising edge
    @(posedge clk_i);
    #1;
  endtask

  function automatic tile_types_pkg::word_t merge_bytes(tile_types_pkg::word_t old_w,
      tile_types_pkg::word_t new_w, tile_types_pkg::be_t be);
    tile_types_pkg::word_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[b*8 +: 8] = new_w[b*8 +: 8];  // Enabled lanes only
    end
    return res;
  endfunction

  function automatic tile_types_pkg::tile_addr_u word_addr(int idx);
    tile_types_pkg::tile_addr_u a;
    a.raw = tile_cfg_pkg::L1_ADDR_START + 32'(idx * 4);  // Consecutive words rotate banks
    return a;
  endfunction

  // L2 memory model with one outstanding access and 1 to 5 cycles of latency
  initial begin : l2_model
    logic [31:0]           addr;
    tile_types_pkg::word_t rdata;
    int                    lat;
    l2_rsp_valid_i = 1'b0;
    l2_rsp_rdata_i = '0;
    forever begin
      tick();
      if (l2_req_valid_o) begin
        addr = l2_req_addr_o;
        l2_req_cnt++;
        rdata = l2_mem.exists(addr) ? l2_mem[addr] : addr ^ 32'h5A5A_A5A5;  // Fill pattern
        if (l2_req_we_o) begin
          l2_mem[addr] = merge_bytes(rdata, l2_req_wdata_o, l2_req_be_o);
          rdata = '0;                        // Store answers with zero data
        end
        lat = 1 + int'($urandom % 5);
        repeat (lat) tick();
        l2_rsp_valid_i = 1'b1;
        l2_rsp_rdata_i = rdata;
        tick();
        l2_rsp_valid_i = 1'b0;
      end
    end
  end

  task automatic check_rsp(tile_types_pkg::word_t got, logic got_err,
      tile_types_pkg::word_t exp, logic exp_err, string what);
    if (got !== exp || got_err !== exp_err) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s got %h err %b, expected %h err %b",
               $time, what, got, got_err, exp, exp_err);
    end
  endtask

  task automatic check_l2_req(tile_types_pkg::tile_addr_u exp_addr, logic exp_we,
      tile_types_pkg::word_t exp_wdata, tile_types_pkg::be_t exp_be, string what);
    if (l2_req_valid_o !== 1'b1 || l2_req_addr_o !== exp_addr.raw ||
        l2_req_we_o !== exp_we || l2_req_wdata_o !== exp_wdata ||
        l2_req_be_o !== exp_be) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s valid %b addr %h we %b data %h be %b",
               $time, what, l2_req_valid_o, l2_req_addr_o, l2_req_we_o, l2_req_wdata_o,
               l2_req_be_o);
      $display("CHECK FAILED at %0t: %s expected addr %h we %b data %h be %b",
               $time, what, exp_addr.raw, exp_we, exp_wdata, exp_be);
    end
  endtask

  task automatic issue_req(tile_types_pkg::tile_addr_u addr, logic we,
      tile_types_pkg::word_t wdata, tile_types_pkg::be_t be);
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    req_we_i    = we;
    req_wdata_i = wdata;
    req_be_i    = be;
    tick();                                  // Sampled at this edge
    req_valid_i = 1'b0;
  endtask

  // Response due after a fixed number of further edges
  task automatic expect_rsp(int edges, tile_types_pkg::word_t exp, logic exp_err, string what);
    for (int i = 1; i <= edges; i++) begin
      tick();
      if (i < edges && rsp_valid_o) begin
        miss_cnt++;
        $display("Response for %s arrived early at %0t", what, $time);
      end
    end
    if (!rsp_valid_o) begin
      miss_cnt++;
      $display("No response for %s at %0t", what, $time);
    end else begin
      check_rsp(rsp_rdata_o, rsp_err_o, exp, exp_err, what);
    end
  endtask

  task automatic wait_l2_rsp(tile_types_pkg::word_t exp, string what);
    bit seen = 1'b0;
    for (int i = 0; i < 10 && !seen; i++) begin
      if (!busy_o) begin
        err_cnt++;
        $display("CHECK FAILED at %0t: %s busy_o low before the response", $time, what);
      end
      tick();
      seen = rsp_valid_o;
    end
    if (!seen) begin
      miss_cnt++;
      $display("No response for %s within 10 cycles", what);
    end else begin
      check_rsp(rsp_rdata_o, rsp_err_o, exp, 1'b0, what);
    end
  endtask

  task automatic l1_fill_readback();
    int                    rows [3] = '{0, 21, 63};
    int                    idx;
    tile_types_pkg::word_t data;
    for (int pass = 0; pass < 2; pass++) begin  // Write everything before reading it back
      for (int r = 0; r < 3; r++) begin
        for (int b = 0; b < 4; b++) begin
          idx = rows[r] * 4 + b;
          if (pass == 0) begin
            data = $urandom;
            l1_shadow[idx] = data;
            issue_req(word_addr(idx), 1'b1, data, 4'hF);
            expect_rsp(2, '0, 1'b0, "L1 full store");
          end else begin
            issue_req(word_addr(idx), 1'b0, '0, 4'hF);
            expect_rsp(2, l1_shadow[idx], 1'b0, "L1 readback");
          end
        end
      end
    end
  endtask

  task automatic partial_byte_write();
    int                    idx;
    tile_types_pkg::word_t data;
    idx  = 86;                                  // Row 21 in bank 2 holds a full random word
    data = $urandom;
    l1_shadow[idx] = merge_bytes(l1_shadow[idx], data, 4'b0101);
    issue_req(word_addr(idx), 1'b1, data, 4'b0101);
    expect_rsp(2, '0, 1'b0, "L1 partial store");
    issue_req(word_addr(idx), 1'b0, '0, 4'hF);
    expect_rsp(2, l1_shadow[idx], 1'b0, "L1 read after partial store");
  endtask

  task automatic back_to_back_reads();
    issue_req(word_addr(0), 1'b0, '0, 4'hF);
    issue_req(word_addr(87), 1'b0, '0, 4'hF);
    issue_req(word_addr(252), 1'b0, '0, 4'hF);  // First response is already due here
    expect_rsp(0, l1_shadow[0], 1'b0, "first of three reads");
    expect_rsp(1, l1_shadow[87], 1'b0, "second of three reads");
    expect_rsp(1, l1_shadow[252], 1'b0, "third of three reads");
  endtask

  task automatic l2_write_read();
    tile_types_pkg::tile_addr_u addr;
    tile_types_pkg::word_t      data;
    addr.raw = 32'h2000_0040;
    data = $urandom;
    issue_req(addr, 1'b1, data, 4'hF);
    check_l2_req(addr, 1'b1, data, 4'hF, "L2 store request");
    wait_l2_rsp('0, "L2 store");
    issue_req(addr, 1'b0, '0, 4'hF);
    check_l2_req(addr, 1'b0, '0, 4'hF, "L2 load request");
    wait_l2_rsp(data, "L2 load");
  endtask

  task automatic unmapped_error();
    tile_types_pkg::tile_addr_u addr;
    int                         n_before;
    n_before = l2_req_cnt;
    addr.raw = 32'h3000_0000;
    issue_req(addr, 1'b0, '0, 4'hF);
    expect_rsp(2, '0, 1'b1, "load outside both regions");
    addr.raw = 32'h1000_0400;                   // One past the L1 region
    issue_req(addr, 1'b1, $urandom, 4'hF);
    expect_rsp(2, '0, 1'b1, "store past the L1 region");
    if (l2_req_cnt != n_before) begin
      miss_cnt++;
      $display("An unmapped address produced an L2 request");
    end
  endtask

  task automatic enable_gating();
    tile_enable_i = 1'b0;
    tick();                                     // Enable register clears here
    issue_req(word_addr(5), 1'b1, ~l1_shadow[5], 4'hF);
    repeat (4) begin
      tick();
      if (rsp_valid_o) begin
        miss_cnt++;
        $display("Response at %0t while the tile was disabled", $time);
      end
    end
    tile_enable_i = 1'b1;
    tick();
    issue_req(word_addr(5), 1'b0, '0, 4'hF);
    expect_rsp(2, l1_shadow[5], 1'b0, "read after a gated store");
  endtask

  initial begin
    void'($urandom(61837));
    rstn_i        = 1'b0;
    tile_enable_i = 1'b1;
    req_valid_i   = 1'b0;
    req_addr_i    = '0;
    req_we_i      = 1'b0;
    req_wdata_i   = '0;
    req_be_i      = '0;
    repeat (4) @(posedge clk_i);
    #1 rstn_i = 1'b1;
    tick();                                     // Enable register sets here
    l1_fill_readback();
    partial_byte_write();
    back_to_back_reads();
    l2_write_read();
    unmapped_error();
    enable_gating();
    $display("Errors: %0d wrong values, %0d response errors", err_cnt, miss_cnt);
    if (err_cnt == 0 && miss_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* verification/tile_mem_path_props.sv */
`timescale 1ns/1ns

module tile_mem_path_props (
  input logic                       clk_i,
  input logic                       rstn_i,
  input logic                       tile_enable_i,
  input logic                       req_valid_i,
  input tile_types_pkg::tile_addr_u req_addr_i,
  input logic                       rsp_valid_o,
  input logic                       busy_o
);

  logic l1_hit;  // Address falls in the scratchpad region

  assign l1_hit = (req_addr_i.raw >= tile_cfg_pkg::L1_ADDR_START) &&
                  (req_addr_i.raw <= tile_cfg_pkg::L1_ADDR_END);

  no_req_when_busy: assert property (@(posedge clk_i) disable iff (!rstn_i)
    req_valid_i |-> !busy_o)
    else $error("Request issued while busy_o was high");

  busy_falls_with_rsp: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $fell(busy_o) |-> rsp_valid_o)
    else $error("busy_o fell without a response");

  // Enable register equals last cycle's enable input once out of reset
  // Response is registered at the second edge and first sampled at the third
  l1_rsp_two_edges: assert property (@(posedge clk_i) disable iff (!rstn_i)
    req_valid_i && l1_hit && !busy_o && $past(tile_enable_i) && $past(rstn_i)
      |-> ##3 rsp_valid_o)
    else $error("L1 response missing two edges after the request");

endmodule

bind tile_mem_path tile_mem_path_props tile_mem_path_props_inst (
  .clk_i(clk_i), .rstn_i(rstn_i), .tile_enable_i(tile_enable_i), .req_valid_i(req_valid_i),
  .req_addr_i(req_addr_i), .rsp_valid_o(rsp_valid_o), .busy_o(busy_o)
);
